/* fp_cmp_pkg.sv */
// #########################################################
// fp compare package
// op and format codes, decoded op, unpacked operand and
// result records, canonical NaN patterns
// #########################################################

package fp_cmp_pkg;

  // operation selected by funct5/funct3
  typedef enum logic [2:0] {
    OP_NONE = 3'd0, // not a compare or min/max, or illegal
    OP_FEQ  = 3'd1,
    OP_FLT  = 3'd2,
    OP_FLE  = 3'd3,
    OP_FMIN = 3'd4,
    OP_FMAX = 3'd5
  } fp_op_e;

  // low bit of insn[26:25], H and Q never get this far
  typedef enum logic {
    FMT_S = 1'b0,
    FMT_D = 1'b1
  } fp_fmt_e;

  // decode stage record, 11 bits
  typedef struct packed {
    logic    valid;
    fp_op_e  op;
    fp_fmt_e fmt;
    logic    illegal;
    logic [4:0] rd;
  } fp_dec_t;

  // one operand after unpack, 67 bits
  typedef struct packed {
    logic        sign;
    logic [10:0] exp;     // S exponent zero-extended
    logic [51:0] man;     // S mantissa zero-extended
    logic        is_zero; // +0 or -0
    logic        is_qnan;
    logic        is_snan;
  } fp_class_t;

  // result record, fp_data sized for FLEN up to 64
  typedef struct packed {
    logic        valid;
    logic        int_wr;   // integer rd write
    logic        fp_wr;    // fp rd write
    logic [4:0]  rd;
    logic [31:0] int_data; // 0 or 1 for compares
    logic [63:0] fp_data;
    logic        nv;       // invalid operation
    logic        illegal;
  } fp_res_t;

  // canonical quiet NaNs, S one already boxed
  localparam logic [63:0] CANON_NAN_S = 64'hffff_ffff_7fc0_0000;
  localparam logic [63:0] CANON_NAN_D = 64'h7ff8_0000_0000_0000;

endpackage

/* fp_op_decode.sv */
// #########################################################
// OP-FP decode for FEQ/FLT/FLE and FMIN/FMAX
// registers the decoded op and both source operands
// #########################################################

`timescale 1ns/1ps

module fp_op_decode #(
  parameter int FLEN = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid, // one-cycle issue strobe
  input  logic [31:0]         insn,
  input  logic [FLEN-1:0]     rs1_val,
  input  logic [FLEN-1:0]     rs2_val,
  output fp_cmp_pkg::fp_dec_t dec,
  output logic [FLEN-1:0]     op_a,
  output logic [FLEN-1:0]     op_b
);

  import fp_cmp_pkg::*;

  localparam logic [6:0] OPC_OP_FP = 7'b1010011;
  localparam logic [4:0] F5_CMP    = 5'b10100;
  localparam logic [4:0] F5_MINMAX = 5'b00101;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [1:0] fmt_bits;
  logic [4:0] funct5;
  logic       fmt_ok;
  fp_op_e     op_nxt;
  fp_dec_t    dec_nxt;

  assign opcode   = insn[6:0];
  assign funct3   = insn[14:12];
  assign fmt_bits = insn[26:25];
  assign funct5   = insn[31:27];

  // S always, D only with a 64-bit register file
  assign fmt_ok = (fmt_bits == 2'b00) || ((fmt_bits == 2'b01) && (FLEN >= 64));

  always_comb begin
    op_nxt = OP_NONE;
    if ((opcode == OPC_OP_FP) && fmt_ok) begin
      if (funct5 == F5_CMP) begin
        case (funct3)
          3'b010:  op_nxt = OP_FEQ;
          3'b001:  op_nxt = OP_FLT;
          3'b000:  op_nxt = OP_FLE;
          default: op_nxt = OP_NONE;
        endcase
      end else if (funct5 == F5_MINMAX) begin
        case (funct3)
          3'b000:  op_nxt = OP_FMIN;
          3'b001:  op_nxt = OP_FMAX;
          default: op_nxt = OP_NONE;
        endcase
      end
    end
  end

  always_comb begin
    dec_nxt       = '0; // bubble when idle
    dec_nxt.valid = in_valid;
    if (in_valid) begin
      dec_nxt.op      = op_nxt;
      dec_nxt.fmt     = fp_fmt_e'(fmt_bits[0]);
      dec_nxt.illegal = (op_nxt == OP_NONE); // anything unmatched
      dec_nxt.rd      = insn[11:7];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec <= '0;
    end else begin
      dec <= dec_nxt;
    end
  end

  // operands follow the strobe, held otherwise
  always_ff @(posedge clk) begin
    if (in_valid) begin
      op_a <= rs1_val;
      op_b <= rs2_val;
    end
  end

  // an illegal slot carries no operation
  a_illegal_no_op: assert property (@(posedge clk) disable iff (!rst_n)
    dec.illegal |-> (dec.valid && (dec.op == OP_NONE)));

endmodule

/* fp_unpack.sv */
// #########################################################
// operand unpack for S or D format
// NaN-box check, field widening, zero/qNaN/sNaN class
// #########################################################

`timescale 1ns/1ps

module fp_unpack #(
  parameter int FLEN = 64
) (
  input  logic [FLEN-1:0]       operand,
  input  fp_cmp_pkg::fp_fmt_e   fmt,
  output fp_cmp_pkg::fp_class_t cls
);

  import fp_cmp_pkg::*;

  logic [31:0] word_s; // single word after box check
  logic [63:0] word_d;
  logic        sign;
  logic [10:0] exp;
  logic [51:0] man;
  logic [10:0] exp_ones;
  logic        man_top; // quiet bit of current format
  logic        is_nan;

  if (FLEN == 64) begin : g_box
    // upper word must be all ones, else canonical qNaN
    assign word_s = (&operand[FLEN-1:32]) ? operand[31:0] : CANON_NAN_S[31:0];
    assign word_d = operand;
  end else begin : g_nobox
    assign word_s = operand[31:0];
    assign word_d = 64'(operand); // D is illegal here
  end

  always_comb begin
    if (fmt == FMT_D) begin
      sign     = word_d[63];
      exp      = word_d[62:52];
      man      = word_d[51:0];
      exp_ones = 11'h7ff;
      man_top  = word_d[51];
    end else begin
      sign     = word_s[31];
      exp      = {3'b000, word_s[30:23]};
      man      = {29'd0, word_s[22:0]};
      exp_ones = 11'h0ff;
      man_top  = word_s[22];
    end
  end

  assign is_nan = (exp == exp_ones) && (man != '0);

  always_comb begin
    cls.sign    = sign;
    cls.exp     = exp;
    cls.man     = man;
    cls.is_zero = (exp == '0) && (man == '0); // subnormals stay nonzero
    cls.is_qnan = is_nan && man_top;
    cls.is_snan = is_nan && !man_top;
    // class flags are exclusive for any format and box state
    a_nan_excl: assert final (!(cls.is_qnan && cls.is_snan));
  end

endmodule

/* fp_compare.sv */
// #########################################################
// compare execute stage
// IEEE equal and less-than, compare bit, min/max pick, NV
// #########################################################

`timescale 1ns/1ps

module fp_compare (
  input  fp_cmp_pkg::fp_dec_t   dec,
  input  fp_cmp_pkg::fp_class_t cls_a,
  input  fp_cmp_pkg::fp_class_t cls_b,
  output logic                  cmp_bit,
  output logic                  pick_b,   // min/max returns rs2
  output logic                  both_nan, // min/max returns canonical NaN
  output logic                  nv
);

  import fp_cmp_pkg::*;

  logic nan_a;
  logic nan_b;
  logic any_nan;
  logic any_snan;
  logic both_zero;
  logic mag_lt;   // |a| < |b|
  logic mag_eq;
  logic a_eq_b;   // +0 == -0
  logic a_lt_b;   // true ordered less-than
  logic a_lt_b_z; // same, but -0 below +0

  assign nan_a    = cls_a.is_qnan | cls_a.is_snan;
  assign nan_b    = cls_b.is_qnan | cls_b.is_snan;
  assign any_nan  = nan_a | nan_b;
  assign both_nan = nan_a & nan_b;
  assign any_snan = cls_a.is_snan | cls_b.is_snan;

  assign both_zero = cls_a.is_zero & cls_b.is_zero;

  // exponent above mantissa, so one unsigned compare orders magnitude
  assign mag_lt = {cls_a.exp, cls_a.man} < {cls_b.exp, cls_b.man};
  assign mag_eq = {cls_a.exp, cls_a.man} == {cls_b.exp, cls_b.man};

  assign a_eq_b = both_zero | ((cls_a.sign == cls_b.sign) & mag_eq);

  always_comb begin
    if (both_zero) begin
      a_lt_b = 1'b0;
    end else if (cls_a.sign != cls_b.sign) begin
      a_lt_b = cls_a.sign; // negative side is smaller
    end else if (cls_a.sign) begin
      a_lt_b = !mag_lt && !mag_eq; // both negative, order flips
    end else begin
      a_lt_b = mag_lt;
    end
  end

  assign a_lt_b_z = both_zero ? (cls_a.sign & ~cls_b.sign) : a_lt_b;

  always_comb begin
    cmp_bit = 1'b0;
    pick_b  = 1'b0;
    nv      = 1'b0;
    case (dec.op)
      OP_FEQ: begin
        cmp_bit = !any_nan && a_eq_b;
        nv      = any_snan; // quiet compare
      end
      OP_FLT: begin
        cmp_bit = !any_nan && a_lt_b;
        nv      = any_nan;  // signalling compare
      end
      OP_FLE: begin
        cmp_bit = !any_nan && (a_lt_b || a_eq_b);
        nv      = any_nan;
      end
      OP_FMIN: begin
        pick_b = nan_a || (!nan_b && !a_lt_b_z); // a NaN yields the other
        nv     = any_snan;
      end
      OP_FMAX: begin
        pick_b = nan_a || (!nan_b && a_lt_b_z);
        nv     = any_snan;
      end
      default: begin
        cmp_bit = 1'b0; // OP_NONE, illegal slot
      end
    endcase
  end

endmodule

/* fp_result.sv */
// #########################################################
// result stage
// builds integer or fp write data, registers the record,
// keeps the sticky invalid-operation flag
// #########################################################

`timescale 1ns/1ps

module fp_result #(
  parameter int FLEN = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  fp_cmp_pkg::fp_dec_t dec,
  input  logic [FLEN-1:0]     op_a,
  input  logic [FLEN-1:0]     op_b,
  input  logic                cmp_bit,
  input  logic                pick_b,
  input  logic                both_nan,
  input  logic                nv,
  input  logic                flags_clr, // one-cycle clear of accrued NV
  output fp_cmp_pkg::fp_res_t res,
  output logic                fflags_nv  // accrued NV level
);

  import fp_cmp_pkg::*;

  logic            issue_ok; // valid and legal
  logic [FLEN-1:0] sel_op;
  logic [63:0]     minmax_data;
  fp_res_t         res_nxt;

  assign issue_ok = dec.valid && !dec.illegal;
  assign sel_op   = pick_b ? op_b : op_a;

  always_comb begin
    if (both_nan) begin
      minmax_data = (dec.fmt == FMT_D) ? CANON_NAN_D : CANON_NAN_S;
    end else if (dec.fmt == FMT_D) begin
      minmax_data = 64'(sel_op);
    end else begin
      minmax_data = {32'hffff_ffff, sel_op[31:0]}; // box S result
    end
  end

  always_comb begin
    res_nxt         = '0;
    res_nxt.valid   = dec.valid;
    res_nxt.rd      = dec.rd;
    res_nxt.illegal = dec.valid && dec.illegal; // no write, no nv
    if (issue_ok) begin
      res_nxt.nv = nv;
      case (dec.op)
        OP_FEQ, OP_FLT, OP_FLE: begin
          res_nxt.int_wr   = 1'b1;
          res_nxt.int_data = {31'd0, cmp_bit};
        end
        OP_FMIN, OP_FMAX: begin
          res_nxt.fp_wr   = 1'b1;
          res_nxt.fp_data = minmax_data;
        end
        default: begin
          res_nxt.nv = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res <= '0;
    end else begin
      res <= res_nxt;
    end
  end

  // set by the result being registered, new nv beats a clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fflags_nv <= 1'b0;
    end else if (res_nxt.nv) begin
      fflags_nv <= 1'b1;
    end else if (flags_clr) begin
      fflags_nv <= 1'b0;
    end
  end

  // one destination file per result
  a_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(res.int_wr && res.fp_wr));

endmodule

/* fp_cmp_unit.sv */
// #########################################################
// floating-point compare unit top
// decode, two unpacks, compare and result, 2-cycle latency
// #########################################################

`timescale 1ns/1ps

module fp_cmp_unit #(
  parameter int FLEN = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic [31:0]         insn,
  input  logic [FLEN-1:0]     rs1_val,
  input  logic [FLEN-1:0]     rs2_val,
  input  logic                flags_clr,
  output fp_cmp_pkg::fp_res_t res,
  output logic                fflags_nv
);

  import fp_cmp_pkg::*;

  fp_dec_t         dec;   // stage 1 register
  logic [FLEN-1:0] op_a;  // rs1 value
  logic [FLEN-1:0] op_b;  // rs2 value
  fp_class_t       cls_a;
  fp_class_t       cls_b;
  logic            cmp_bit;
  logic            pick_b;
  logic            both_nan;
  logic            nv;

  fp_op_decode #(.FLEN(FLEN)) decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .insn     (insn),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .dec      (dec),
    .op_a     (op_a),
    .op_b     (op_b)
  );

  fp_unpack #(.FLEN(FLEN)) unpack_a (.operand(op_a), .fmt(dec.fmt), .cls(cls_a));
  fp_unpack #(.FLEN(FLEN)) unpack_b (.operand(op_b), .fmt(dec.fmt), .cls(cls_b));

  // combinational, between the two register stages
  fp_compare compare (
    .dec      (dec),
    .cls_a    (cls_a),
    .cls_b    (cls_b),
    .cmp_bit  (cmp_bit),
    .pick_b   (pick_b),
    .both_nan (both_nan),
    .nv       (nv)
  );

  fp_result #(.FLEN(FLEN)) result (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec),
    .op_a      (op_a),
    .op_b      (op_b),
    .cmp_bit   (cmp_bit),
    .pick_b    (pick_b),
    .both_nan  (both_nan),
    .nv        (nv),
    .flags_clr (flags_clr),
    .res       (res),
    .fflags_nv (fflags_nv)
  );

endmodule

/* tb_fp_cmp_unit.sv */
// ##########################################################
// testbench for the fp compare unit
// replays the trace file, checks each result and sticky NV
// ##########################################################

`timescale 1ns/1ps

module tb_fp_cmp_unit;

  import fp_cmp_pkg::*;

  localparam int FLEN     = 64;
  localparam int MAX_LINE = 64; // trace capacity

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  logic [31:0]     insn;
  logic [FLEN-1:0] rs1_val;
  logic [FLEN-1:0] rs2_val;
  logic            flags_clr;
  fp_res_t         res;
  logic            fflags_nv;

  // trace columns, one entry per line
  string       t_name [MAX_LINE];
  logic [31:0] t_insn [MAX_LINE];
  logic [63:0] t_rs1  [MAX_LINE];
  logic [63:0] t_rs2  [MAX_LINE];
  string       t_kind [MAX_LINE]; // int, fp or illegal
  logic [63:0] t_val  [MAX_LINE];
  logic        t_nv   [MAX_LINE];

  int   n_lines  = 0;
  int   err_cnt  = 0;
  int   pass_cnt = 0;
  int   fail_cnt = 0;
  int   cyc      = 0;   // rising edges seen
  int   exp_q [$];      // trace index per issued op, oldest first
  int   issue_q [$];    // cycle of each issue
  logic any_nv = 1'b0;  // some line expects nv

  fp_cmp_unit #(.FLEN(FLEN)) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .insn      (insn),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .flags_clr (flags_clr),
    .res       (res),
    .fflags_nv (fflags_nv)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_int(input string sig, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("Fail %s got %h expected %h", sig, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_fp(input string sig, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("Fail %s got %h expected %h", sig, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_level(input string sig, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail %s got %h expected %h", sig, got, want);
      err_cnt++;
    end
  endtask

  // write enables, nv and illegal of one record
  task automatic check_flags(input fp_res_t got, input fp_res_t want);
    check_level("res.int_wr", got.int_wr, want.int_wr);
    check_level("res.fp_wr", got.fp_wr, want.fp_wr);
    check_level("res.nv", got.nv, want.nv);
    check_level("res.illegal", got.illegal, want.illegal);
  endtask

  task automatic log_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %-14s ok", name);
    end else begin
      fail_cnt++;
      $display("test %-14s failed", name);
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          code;
    int          nv_col;
    string       line;
    string       name;
    string       kind;
    logic [31:0] ins;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] v;
    fd = $fopen("fp_cmp_trace.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && n_lines < MAX_LINE) begin
      code = $fgets(line, fd);
      if (code > 0 && line.getc(0) != "#") begin // skip column notes
        code = $sscanf(line, "%s %h %h %h %s %h %h", name, ins, a, b, kind, v, nv_col);
        if (code == 7) begin
          t_name[n_lines] = name;
          t_insn[n_lines] = ins;
          t_rs1[n_lines]  = a;
          t_rs2[n_lines]  = b;
          t_kind[n_lines] = kind;
          t_val[n_lines]  = v;
          t_nv[n_lines]   = (nv_col != 0);
          if (nv_col != 0) any_nv = 1'b1;
          n_lines++;
        end
      end
    end
    $fclose(fd);
  endtask

  // pairs the oldest pending line with the record on res
  task automatic match_result();
    int      idx;
    int      issued;
    int      errs_before;
    fp_res_t want;
    if (exp_q.size() == 0) begin
      $display("a result came out with no instruction pending");
      err_cnt++;
      fail_cnt++;
      return;
    end
    idx         = exp_q.pop_front();
    issued      = issue_q.pop_front();
    errs_before = err_cnt;
    want        = '0;
    want.valid  = 1'b1;
    want.rd     = t_insn[idx][11:7]; // rd field of the encoding
    want.nv     = t_nv[idx];
    if (t_kind[idx] == "int") begin
      want.int_wr   = 1'b1;
      want.int_data = t_val[idx][31:0];
    end else if (t_kind[idx] == "fp") begin
      want.fp_wr   = 1'b1;
      want.fp_data = t_val[idx];
    end else begin
      want.illegal = 1'b1; // no write, nv stays low
    end
    // two register stages from issue to result
    if (cyc - issued != 2) begin
      $display("result of %s came %0d cycles after issue instead of 2", t_name[idx],
               cyc - issued);
      err_cnt++;
    end
    check_flags(res, want);
    if (want.int_wr || want.fp_wr) check_int("res.rd", 32'(res.rd), 32'(want.rd));
    if (want.int_wr) check_int("res.int_data", res.int_data, want.int_data);
    if (want.fp_wr) check_fp("res.fp_data", res.fp_data, want.fp_data);
    if (want.nv) check_level("fflags_nv", fflags_nv, 1'b1); // same cycle
    log_test(t_name[idx], errs_before);
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n && res.valid) match_result();
  end

  initial begin : watchdog
    wait (n_lines > 0);
    repeat (n_lines * 4 + 50) @(posedge clk);
    $display("timeout, results still missing after %0d cycles", n_lines * 4 + 50);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    int unsigned gap;
    int          errs_before;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    insn      = '0;
    rs1_val   = '0;
    rs2_val   = '0;
    flags_clr = 1'b0;
    void'($urandom(32'ha065)); // seed once
    load_trace();
    if (n_lines == 0) begin
      $display("trace file missing or holds no test lines");
      $display(">>> FAIL");
      $finish;
    end else begin
      repeat (3) @(posedge clk);
      #2;
      rst_n       = 1'b1;
      errs_before = err_cnt;
      check_level("fflags_nv", fflags_nv, 1'b0);
      check_level("res.valid", res.valid, 1'b0);
      log_test("reset_state", errs_before);
      for (int i = 0; i < n_lines; i++) begin
        gap = $urandom_range(2, 0); // 0 gives back-to-back issue
        repeat (gap) begin
          @(posedge clk);
          #2;
          in_valid = 1'b0;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        insn     = t_insn[i];
        rs1_val  = t_rs1[i];
        rs2_val  = t_rs2[i];
        exp_q.push_back(i);
        issue_q.push_back(cyc);
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      // accrued NV holds until the clear pulse
      errs_before = err_cnt;
      @(negedge clk);
      check_level("fflags_nv", fflags_nv, any_nv);
      @(posedge clk);
      #2;
      flags_clr = 1'b1;
      @(posedge clk);
      #2;
      flags_clr = 1'b0;
      @(negedge clk);
      check_level("fflags_nv", fflags_nv, 1'b0);
      log_test("sticky_clear", errs_before);
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

/* fp_cmp_trace.txt */
# name insn rs1 rs2 kind(int|fp|illegal) expected nv, all hex
# S operands are NaN-boxed unless the name says unbox
feq_s_eq     a020a1d3 ffffffff3f800000 ffffffff3f800000 int 1 0
flt_s_lt     a02091d3 ffffffff3f800000 ffffffff40000000 int 1 0
fle_s_gt     a02081d3 ffffffff40000000 ffffffff3f800000 int 0 0
flt_s_neg    a02091d3 ffffffffc0000000 ffffffffbf800000 int 1 0
flt_s_zero   a02091d3 ffffffff80000000 ffffffff00000000 int 0 0
flt_d_neg    a22091d3 bff0000000000000 c000000000000000 int 0 0
feq_d_zero   a220a1d3 0000000000000000 8000000000000000 int 1 0
fle_d_mix    a22081d3 bff0000000000000 3ff0000000000000 int 1 0
feq_s_qnan   a020a1d3 ffffffff7fc00000 ffffffff3f800000 int 0 0
flt_s_qnan   a02091d3 ffffffff3f800000 ffffffff7fc00000 int 0 1
fle_d_qnan   a22081d3 7ff8000000000000 3ff0000000000000 int 0 1
feq_d_snan   a220a1d3 7ff0000000000001 3ff0000000000000 int 0 1
fmin_s_nan   282081d3 ffffffff7fc00000 ffffffff40000000 fp ffffffff40000000 0
fmax_d_snan  2a2091d3 3ff0000000000000 7ff0000000000001 fp 3ff0000000000000 1
fmin_d_both  2a2081d3 7ff8000000000000 7ff8000000000000 fp 7ff8000000000000 0
fmax_s_both  282091d3 ffffffff7f800001 ffffffff7fc00000 fp ffffffff7fc00000 1
fmin_s_zero  282081d3 ffffffff00000000 ffffffff80000000 fp ffffffff80000000 0
fmax_d_zero  2a2091d3 8000000000000000 0000000000000000 fp 0000000000000000 0
fmin_d_ord   2a2081d3 4000000000000000 bff0000000000000 fp bff0000000000000 0
fmax_s_ord   282091d3 ffffffffbf800000 ffffffff3f800000 fp ffffffff3f800000 0
feq_s_unbox  a020a1d3 000000003f800000 ffffffff3f800000 int 0 0
flt_s_unbox  a02091d3 ffffffff3f800000 7fffffff3f800000 int 0 1
fmin_s_unbox 282081d3 000000003f800000 ffffffff40000000 fp ffffffff40000000 0
bad_funct3   a020b1d3 ffffffff3f800000 ffffffff3f800000 illegal 0 0
bad_fmt_h    a420a1d3 ffffffff3f800000 ffffffff3f800000 illegal 0 0
bad_opcode   a020a1b3 ffffffff3f800000 ffffffff3f800000 illegal 0 0

/* all.f */
fp_cmp_pkg.sv
fp_op_decode.sv
fp_unpack.sv
fp_compare.sv
fp_result.sv
fp_cmp_unit.sv
tb_fp_cmp_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_fp_cmp_unit
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
